/* verilog/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	typedef logic [15:0] cpu_word_t;
	typedef logic [2:0] cpu_reg_idx_t;
	typedef cpu_word_t [7:0] cpu_regs_t;

	typedef enum logic [3:0] {
		op_mv   = 4'b0000,
		op_add  = 4'b0001,
		op_sub  = 4'b0010,
		op_cmp  = 4'b0011,
		op_ld   = 4'b0100,
		op_st   = 4'b0101,
		op_mvhi = 4'b0110,
		op_j    = 4'b1000,
		op_jz   = 4'b1001,
		op_jn   = 4'b1010,
		op_call = 4'b1100
	} cpu_opcode_e;

	// return address of call
	localparam cpu_reg_idx_t link_reg = 3'd7;

	function automatic cpu_opcode_e ir_op(cpu_word_t ir);
		return cpu_opcode_e'(ir[3:0]);
	endfunction

	function automatic logic ir_imm(cpu_word_t ir);
		return ir[4];
	endfunction

	function automatic cpu_reg_idx_t ir_rx(cpu_word_t ir);
		return ir[7:5];
	endfunction

	function automatic cpu_reg_idx_t ir_ry(cpu_word_t ir);
		return ir[10:8];
	endfunction

	// sign extended
	function automatic cpu_word_t ir_imm8(cpu_word_t ir);
		return {{8{ir[15]}}, ir[15:8]};
	endfunction

	// word offset turned into bytes
	function automatic cpu_word_t ir_br_off(cpu_word_t ir);
		return {{4{ir[15]}}, ir[15:5], 1'b0};
	endfunction

	function automatic logic op_is_branch(cpu_opcode_e op);
		return op[3];
	endfunction

	// operand b comes from ry
	function automatic logic ir_uses_ry(cpu_word_t ir);
		cpu_opcode_e op;
		op = ir_op(ir);
		if (op == op_ld || op == op_st) begin
			return 1'b1;
		end
		return !ir_imm(ir) && !op_is_branch(op) && op != op_mvhi;
	endfunction

endpackage

/* verilog/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;
	import cpu_isa_pkg::*;

	// fetch to decode, the instruction word arrives separately
	typedef struct packed {
		cpu_word_t pc;
	} cpu_fd_t;

	typedef struct packed {
		cpu_word_t pc;
		cpu_word_t ir;
		cpu_word_t a;
		cpu_word_t b;
		cpu_reg_idx_t rx;
		cpu_reg_idx_t ry;
	} cpu_dx_t;

	typedef struct packed {
		cpu_word_t pc;
		cpu_word_t ir;
		cpu_word_t g;
	} cpu_xw_t;

endpackage

/* verilog/cpu_stage_reg.sv */
`timescale 1ns/10ps

module cpu_stage_reg #(
	parameter type T_PAYLOAD = logic
) (
	input  logic     clk,
	input  logic     i_rst_n,
	input  logic     i_flush,
	input  logic     i_valid,
	input  T_PAYLOAD i_data,
	output logic     o_valid,
	output T_PAYLOAD o_data
);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid && !i_flush;
		end
	end

	// payload moves every cycle, valid says whether it counts
	always_ff @(posedge clk) begin
		o_data <= i_data;
	end

	a_valid_known: assert property (
		@(posedge clk) disable iff (!i_rst_n) !$isunknown(o_valid)
	);

endmodule

/* verilog/cpu_register_file.sv */
`timescale 1ns/10ps

module cpu_register_file
	import cpu_isa_pkg::*;
(
	input  logic         clk,
	input  logic         i_rst_n,
	input  cpu_reg_idx_t i_rx,
	input  cpu_reg_idx_t i_ry,
	input  logic         i_rw_en,
	input  cpu_reg_idx_t i_rw,
	input  cpu_word_t    i_rw_data,
	output cpu_word_t    o_rx_data,
	output cpu_word_t    o_ry_data,
	output cpu_regs_t    o_regs
);

	cpu_regs_t regs;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			regs <= '0;
		end else if (i_rw_en) begin
			regs[i_rw] <= i_rw_data;
		end
	end

	// write-through, decode sees what writeback stores this cycle
	assign o_rx_data = (i_rw_en && i_rw == i_rx) ? i_rw_data : regs[i_rx];
	assign o_ry_data = (i_rw_en && i_rw == i_ry) ? i_rw_data : regs[i_ry];

	assign o_regs = regs;

endmodule

/* verilog/cpu_fetch.sv */
`timescale 1ns/10ps

module cpu_fetch
	import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
	parameter cpu_word_t P_RESET_PC = '0
) (
	input  logic      clk,
	input  logic      i_rst_n,
	input  logic      i_br_en,
	input  cpu_word_t i_br_pc,
	output cpu_word_t o_pc_addr,
	output logic      o_pc_rd,
	output cpu_fd_t   o_fd
);

	cpu_word_t pc;
	logic run;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pc <= P_RESET_PC;
			run <= 1'b0;
		end else begin
			run <= 1'b1;
			if (i_br_en) begin
				pc <= i_br_pc;
			end else if (run) begin
				pc <= pc + 16'd2;
			end
		end
	end

	assign o_pc_addr = pc;
	assign o_pc_rd = run;
	assign o_fd = '{pc: pc};

endmodule

/* verilog/cpu_decode.sv */
`timescale 1ns/10ps

module cpu_decode
	import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
	input  cpu_fd_t      i_fd,
	input  cpu_word_t    i_ir,
	input  cpu_word_t    i_rx_data,
	input  cpu_word_t    i_ry_data,
	output cpu_reg_idx_t o_rx,
	output cpu_reg_idx_t o_ry,
	output cpu_dx_t      o_dx
);

	cpu_opcode_e op;

	assign op = ir_op(i_ir);
	assign o_rx = ir_rx(i_ir);
	assign o_ry = ir_ry(i_ir);

	always_comb begin
		o_dx.pc = i_fd.pc;
		o_dx.ir = i_ir;
		o_dx.rx = o_rx;
		o_dx.ry = o_ry;
		o_dx.a = i_rx_data;
		if (op_is_branch(op)) begin
			o_dx.b = ir_br_off(i_ir);
		end else if (op == op_mvhi) begin
			// immediate lands in the high byte
			o_dx.b = ir_imm8(i_ir) << 8;
		end else if (ir_uses_ry(i_ir)) begin
			o_dx.b = i_ry_data;
		end else begin
			o_dx.b = ir_imm8(i_ir);
		end
	end

endmodule

/* verilog/cpu_forward_ctrl.sv */
`timescale 1ns/10ps

module cpu_forward_ctrl
	import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
	input  cpu_dx_t      i_dx,
	input  logic         i_rw_en,
	input  cpu_reg_idx_t i_rw,
	input  cpu_word_t    i_rw_data,
	output cpu_word_t    o_a,
	output cpu_word_t    o_b
);

	logic fwd_a;
	logic fwd_b;

	// the writeback instruction is the one right ahead of execute
	assign fwd_a = i_rw_en && i_rw == i_dx.rx;
	// immediates and branch offsets are never bypassed
	assign fwd_b = i_rw_en && i_rw == i_dx.ry && ir_uses_ry(i_dx.ir);

	assign o_a = fwd_a ? i_rw_data : i_dx.a;
	assign o_b = fwd_b ? i_rw_data : i_dx.b;

endmodule

/* verilog/cpu_execute.sv */
`timescale 1ns/10ps

module cpu_execute
	import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
	input  logic      clk,
	input  logic      i_rst_n,
	input  logic      i_valid,
	input  cpu_dx_t   i_dx,
	input  cpu_word_t i_a,
	input  cpu_word_t i_b,
	output cpu_xw_t   o_xw,
	output logic      o_br_en,
	output cpu_word_t o_br_pc,
	output cpu_word_t o_mem_addr,
	output cpu_word_t o_mem_wrdata,
	output logic      o_mem_rd,
	output logic      o_mem_wr
);

	cpu_opcode_e op;
	cpu_word_t pc_next;
	cpu_word_t alu;
	logic flag_n;
	logic flag_z;
	logic set_flags;
	logic taken;

	assign op = ir_op(i_dx.ir);
	assign pc_next = i_dx.pc + 16'd2;

	always_comb begin
		case (op)
			op_add:         alu = i_a + i_b;
			op_sub, op_cmp: alu = i_a - i_b;
			// mvhi keeps the low byte of rx
			op_mvhi:        alu = {i_b[15:8], i_a[7:0]};
			op_call:        alu = pc_next;
			default:        alu = i_b;
		endcase
	end

	assign set_flags = i_valid && (op == op_add || op == op_sub || op == op_cmp);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			flag_n <= 1'b0;
			flag_z <= 1'b0;
		end else if (set_flags) begin
			flag_n <= alu[15];
			flag_z <= alu == '0;
		end
	end

	always_comb begin
		case (op)
			op_j, op_call: taken = 1'b1;
			op_jz:         taken = flag_z;
			op_jn:         taken = flag_n;
			default:       taken = 1'b0;
		endcase
	end

	assign o_br_en = i_valid && taken;
	// register form jumps to rx
	assign o_br_pc = ir_imm(i_dx.ir) ? pc_next + i_b : i_a;

	// address from ry, store data from rx
	assign o_mem_rd = i_valid && op == op_ld;
	assign o_mem_wr = i_valid && op == op_st;
	assign o_mem_addr = i_b;
	assign o_mem_wrdata = i_a;

	assign o_xw = '{pc: i_dx.pc, ir: i_dx.ir, g: alu};

	a_mem_excl: assert property (
		@(posedge clk) disable iff (!i_rst_n) !(o_mem_rd && o_mem_wr)
	);

	// flush of s23 means the next slot can never branch
	a_br_single: assert property (
		@(posedge clk) disable iff (!i_rst_n) o_br_en |=> !o_br_en
	);

endmodule

/* verilog/cpu_writeback.sv */
`timescale 1ns/10ps

module cpu_writeback
	import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
	input  logic         i_valid,
	input  cpu_xw_t      i_xw,
	input  cpu_word_t    i_mem_rddata,
	output logic         o_rw_en,
	output cpu_reg_idx_t o_rw,
	output cpu_word_t    o_rw_data
);

	cpu_opcode_e op;
	logic writes;

	assign op = ir_op(i_xw.ir);

	always_comb begin
		case (op)
			op_mv, op_add, op_sub, op_mvhi, op_ld, op_call: writes = 1'b1;
			default: writes = 1'b0;
		endcase
	end

	assign o_rw_en = i_valid && writes;
	assign o_rw = (op == op_call) ? link_reg : ir_rx(i_xw.ir);
	// load data answers in this cycle
	assign o_rw_data = (op == op_ld) ? i_mem_rddata : i_xw.g;

endmodule

/* verilog/cpu.sv */
`timescale 1ns/10ps

module cpu
	import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
	parameter cpu_word_t P_RESET_PC = '0
) (
	input  logic      clk,
	input  logic      i_rst_n,

	output cpu_word_t o_pc_addr,
	output logic      o_pc_rd,
	input  cpu_word_t i_pc_rddata,

	output cpu_word_t o_ldst_addr,
	output logic      o_ldst_rd,
	output logic      o_ldst_wr,
	input  cpu_word_t i_ldst_rddata,
	output cpu_word_t o_ldst_wrdata,

	output cpu_regs_t o_tb_regs
);

	cpu_reg_idx_t rx, ry, rw;
	cpu_word_t rx_data, ry_data, rw_data;
	logic rw_en;
	logic br_en;
	cpu_word_t br_pc;
	cpu_fd_t fd_in, fd_out;
	cpu_dx_t dx_in, dx_out;
	cpu_xw_t xw_in, xw_out;
	logic s12_valid, s23_valid, s34_valid;
	cpu_word_t fwd_a, fwd_b;

	cpu_register_file regs0 (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_rx(rx),
		.i_ry(ry),
		.i_rw_en(rw_en),
		.i_rw(rw),
		.i_rw_data(rw_data),
		.o_rx_data(rx_data),
		.o_ry_data(ry_data),
		.o_regs(o_tb_regs)
	);

	cpu_fetch #(.P_RESET_PC(P_RESET_PC)) fetch0 (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_br_en(br_en),
		.i_br_pc(br_pc),
		.o_pc_addr(o_pc_addr),
		.o_pc_rd(o_pc_rd),
		.o_fd(fd_in)
	);

	// taken branch drops the two younger slots
	cpu_stage_reg #(.T_PAYLOAD(cpu_fd_t)) s12 (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_flush(br_en),
		.i_valid(o_pc_rd),
		.i_data(fd_in),
		.o_valid(s12_valid),
		.o_data(fd_out)
	);

	cpu_decode decode0 (
		.i_fd(fd_out),
		.i_ir(i_pc_rddata),
		.i_rx_data(rx_data),
		.i_ry_data(ry_data),
		.o_rx(rx),
		.o_ry(ry),
		.o_dx(dx_in)
	);

	cpu_stage_reg #(.T_PAYLOAD(cpu_dx_t)) s23 (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_flush(br_en),
		.i_valid(s12_valid),
		.i_data(dx_in),
		.o_valid(s23_valid),
		.o_data(dx_out)
	);

	cpu_forward_ctrl forward0 (
		.i_dx(dx_out),
		.i_rw_en(rw_en),
		.i_rw(rw),
		.i_rw_data(rw_data),
		.o_a(fwd_a),
		.o_b(fwd_b)
	);

	cpu_execute execute0 (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_valid(s23_valid),
		.i_dx(dx_out),
		.i_a(fwd_a),
		.i_b(fwd_b),
		.o_xw(xw_in),
		.o_br_en(br_en),
		.o_br_pc(br_pc),
		.o_mem_addr(o_ldst_addr),
		.o_mem_wrdata(o_ldst_wrdata),
		.o_mem_rd(o_ldst_rd),
		.o_mem_wr(o_ldst_wr)
	);

	cpu_stage_reg #(.T_PAYLOAD(cpu_xw_t)) s34 (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_flush(1'b0),
		.i_valid(s23_valid),
		.i_data(xw_in),
		.o_valid(s34_valid),
		.o_data(xw_out)
	);

	cpu_writeback writeback0 (
		.i_valid(s34_valid),
		.i_xw(xw_out),
		.i_mem_rddata(i_ldst_rddata),
		.o_rw_en(rw_en),
		.o_rw(rw),
		.o_rw_data(rw_data)
	);

endmodule

/* bench/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb
	import cpu_isa_pkg::*;
();

	localparam cpu_word_t P_RESET_PC = 16'h0000;
	localparam int PROG_LEN = 36;
	localparam int WAIT_LIMIT = 1000;
	localparam logic [31:0] SEED = 32'h7b64bda3;
	// only the flushed slots write this register
	localparam cpu_reg_idx_t MARK_REG = 3'd6;

	logic clk;
	logic rst_n;
	cpu_word_t pc_addr;
	logic pc_rd;
	cpu_word_t pc_rddata;
	cpu_word_t ldst_addr;
	logic ldst_rd;
	logic ldst_wr;
	cpu_word_t ldst_rddata;
	cpu_word_t ldst_wrdata;
	cpu_regs_t tb_regs;

	cpu_word_t prog [PROG_LEN];
	cpu_word_t imem [256];
	cpu_word_t dmem [256];
	cpu_word_t ref_mem [256];
	cpu_word_t st_addr [$];
	cpu_word_t st_data [$];
	cpu_regs_t exp_regs;
	cpu_word_t halt_pc;
	int st_idx;
	int val_errs;
	int other_errs;

	cpu #(.P_RESET_PC(P_RESET_PC)) dut0 (
		.clk(clk),
		.i_rst_n(rst_n),
		.o_pc_addr(pc_addr),
		.o_pc_rd(pc_rd),
		.i_pc_rddata(pc_rddata),
		.o_ldst_addr(ldst_addr),
		.o_ldst_rd(ldst_rd),
		.o_ldst_wr(ldst_wr),
		.i_ldst_rddata(ldst_rddata),
		.o_ldst_wrdata(ldst_wrdata),
		.o_tb_regs(tb_regs)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic check_word(input string name, input cpu_word_t got, input cpu_word_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_strobe(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_regs(input cpu_regs_t got, input cpu_regs_t exp);
		cpu_reg_idx_t idx;
		for (int i = 0; i < 8; i++) begin
			idx = cpu_reg_idx_t'(i);
			if (got[idx] !== exp[idx]) begin
				$display("ERR o_tb_regs[%0d] got %h expected %h", i, got[idx], exp[idx]);
				val_errs++;
			end
		end
	endtask

	// memories answer one cycle after the strobe
	// stores are checked in program order
	always @(posedge clk) begin
		if (pc_rd) begin
			pc_rddata <= imem[pc_addr[8:1]];
		end
		if (ldst_rd) begin
			ldst_rddata <= dmem[ldst_addr[8:1]];
		end
		if (ldst_wr) begin
			dmem[ldst_addr[8:1]] <= ldst_wrdata;
			if (st_idx < st_addr.size()) begin
				check_word("o_ldst_addr", ldst_addr, st_addr[st_idx]);
				check_word("o_ldst_wrdata", ldst_wrdata, st_data[st_idx]);
			end else begin
				$display("store number %0d was not expected", st_idx + 1);
				other_errs++;
			end
			st_idx++;
		end
	end

	function automatic cpu_word_t reg_form(cpu_opcode_e op, cpu_reg_idx_t rx,
		cpu_reg_idx_t ry);
		return {5'b00000, ry, rx, 1'b0, op};
	endfunction

	function automatic cpu_word_t imm_form(cpu_opcode_e op, cpu_reg_idx_t rx,
		logic [7:0] imm);
		return {imm, rx, 1'b1, op};
	endfunction

	// offset in words from pc plus 2
	function automatic cpu_word_t rel_branch(cpu_opcode_e op, logic [10:0] off);
		return {off, 1'b1, op};
	endfunction

	function automatic cpu_word_t reg_branch(cpu_opcode_e op, cpu_reg_idx_t rx);
		return {8'h00, rx, 1'b0, op};
	endfunction

	task automatic load_program();
		cpu_word_t marker;
		marker = imm_form(op_mv, MARK_REG, 8'h5a);
		prog[0] = imm_form(op_mv, 3'd1, 8'h05);
		prog[1] = imm_form(op_mv, 3'd2, 8'hfd);
		prog[2] = reg_form(op_add, 3'd1, 3'd2);
		prog[3] = imm_form(op_mvhi, 3'd1, 8'h12);
		prog[4] = imm_form(op_sub, 3'd2, 8'h01);
		prog[5] = reg_form(op_add, 3'd1, 3'd1);
		prog[6] = reg_form(op_mv, 3'd3, 3'd1);
		prog[7] = imm_form(op_mv, 3'd4, 8'h40);
		// load result used right away
		prog[8] = reg_form(op_ld, 3'd5, 3'd4);
		prog[9] = reg_form(op_add, 3'd5, 3'd1);
		prog[10] = reg_form(op_st, 3'd5, 3'd4);
		prog[11] = imm_form(op_mv, 3'd4, 8'h42);
		prog[12] = reg_form(op_st, 3'd3, 3'd4);
		prog[13] = reg_form(op_ld, 3'd0, 3'd4);
		prog[14] = reg_form(op_cmp, 3'd1, 3'd3);
		// not taken as N is clear
		prog[15] = rel_branch(op_jn, 11'd1);
		prog[16] = rel_branch(op_jz, 11'd2);
		prog[17] = marker;
		prog[18] = marker;
		prog[19] = reg_form(op_cmp, 3'd2, 3'd1);
		// not taken as Z is clear
		prog[20] = rel_branch(op_jz, 11'd5);
		prog[21] = rel_branch(op_jn, 11'd2);
		prog[22] = marker;
		prog[23] = marker;
		prog[24] = imm_form(op_mv, 3'd4, 8'h3a);
		prog[25] = reg_branch(op_j, 3'd4);
		prog[26] = marker;
		prog[27] = marker;
		prog[28] = marker;
		prog[29] = rel_branch(op_call, 11'd3);
		prog[30] = marker;
		prog[31] = marker;
		prog[32] = marker;
		prog[33] = reg_form(op_st, 3'd7, 3'd4);
		prog[34] = imm_form(op_add, 3'd0, 8'h01);
		prog[35] = rel_branch(op_j, 11'h7ff);
	endtask

	// instruction by instruction reference model
	task automatic run_model();
		cpu_regs_t r;
		cpu_word_t pc;
		cpu_word_t npc;
		cpu_word_t ir;
		cpu_word_t src;
		cpu_word_t res;
		cpu_word_t target;
		logic [3:0] op;
		cpu_reg_idx_t rx;
		cpu_reg_idx_t ry;
		logic fn;
		logic fz;
		logic taken;
		logic done;
		int steps;
		r = '0;
		pc = P_RESET_PC;
		fn = 1'b0;
		fz = 1'b0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < WAIT_LIMIT) begin
			ir = imem[pc[8:1]];
			op = ir[3:0];
			rx = ir[7:5];
			ry = ir[10:8];
			src = ir[4] ? {{8{ir[15]}}, ir[15:8]} : r[ry];
			npc = pc + 16'd2;
			target = ir[4] ? npc + {{4{ir[15]}}, ir[15:5], 1'b0} : r[rx];
			taken = 1'b0;
			case (op)
				op_mv: r[rx] = src;
				op_add, op_sub, op_cmp: begin
					res = (op == op_add) ? r[rx] + src : r[rx] - src;
					fz = (res == 16'h0000);
					fn = res[15];
					if (op != op_cmp) begin
						r[rx] = res;
					end
				end
				op_mvhi: r[rx] = {ir[15:8], r[rx][7:0]};
				op_ld: r[rx] = ref_mem[r[ry][8:1]];
				op_st: begin
					st_addr.push_back(r[ry]);
					st_data.push_back(r[rx]);
					ref_mem[r[ry][8:1]] = r[rx];
				end
				op_j: taken = 1'b1;
				op_jz: taken = fz;
				op_jn: taken = fn;
				op_call: begin
					taken = 1'b1;
					r[7] = npc;
				end
				default: ;
			endcase
			if (taken) begin
				if (target == pc) begin
					done = 1'b1;
					halt_pc = pc;
				end
				npc = target;
			end
			pc = npc;
			steps++;
		end
		exp_regs = r;
		if (!done) begin
			$display("reference model never reached the halt loop");
			other_errs++;
		end
	endtask

	initial begin
		int n;
		int seen;
		logic [31:0] rnd;
		rst_n = 1'b0;
		pc_rddata = '0;
		ldst_rddata = '0;
		st_idx = 0;
		val_errs = 0;
		other_errs = 0;
		halt_pc = P_RESET_PC;
		rnd = $urandom(SEED);
		load_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			rnd = $urandom;
			dmem[i] = rnd[15:0];
			ref_mem[i] = rnd[15:0];
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			imem[i] = prog[i];
		end
		run_model();

		repeat (15) @(posedge clk);
		@(negedge clk);
		check_strobe("o_pc_rd", pc_rd, 1'b0);
		check_strobe("o_ldst_rd", ldst_rd, 1'b0);
		check_strobe("o_ldst_wr", ldst_wr, 1'b0);
		check_regs(tb_regs, '0);
		@(posedge clk);
		rst_n <= 1'b1;

		n = 0;
		@(negedge clk);
		while (!pc_rd && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!pc_rd) begin
			$display("no instruction fetch after reset release");
			other_errs++;
		end else begin
			check_word("o_pc_addr", pc_addr, P_RESET_PC);
		end

		// the halt jump refetches its own address
		seen = 0;
		n = 0;
		while (seen < 2 && n < WAIT_LIMIT) begin
			@(negedge clk);
			check_word("o_tb_regs[6]", tb_regs[MARK_REG], 16'h0000);
			if (pc_rd && pc_addr == halt_pc) begin
				seen++;
			end
			n++;
		end
		if (seen < 2) begin
			$display("timeout while waiting for the halt loop");
			other_errs++;
		end

		repeat (2) @(negedge clk);
		check_regs(tb_regs, exp_regs);
		if (st_idx != st_addr.size()) begin
			$display("%0d stores seen, %0d expected", st_idx, st_addr.size());
			other_errs++;
		end

		$display("value errors: %0d, other errors: %0d", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/cpu_stage_reg.sv
verilog/cpu_register_file.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_forward_ctrl.sv
verilog/cpu_execute.sv
verilog/cpu_writeback.sv
verilog/cpu.sv
bench/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
